// ==== bench/mem_subsys_chk.sv ====
// Bound protocol checks on the core strobe handshake and the CPU acknowledge
module mem_subsys_chk #(
  parameter int XLEN = biu_pkg::DEF_XLEN,
  parameter int PLEN = biu_pkg::DEF_PLEN
)
(
  input logic                clk_i,
  input logic                rst_ni,
  input logic                biu_stb_o,
  input logic                biu_stb_ack_i,
  input logic [PLEN-1:0]     biu_adr_o,
  input biu_pkg::biu_size_t  biu_size_o,
  input biu_pkg::biu_prot_t  biu_prot_o,
  input logic                biu_we_o,
  input logic [XLEN-1:0]     biu_d_o,
  input logic                mem_ack_o,
  input logic                mem_err_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // Accepted strobes and delivered acknowledges
  logic [15:0] stb_cnt;
  logic [15:0] ack_cnt;
  // Read by the testbench at the end of the run
  int unsigned fail_cnt = 0;

  always_ff @(posedge clk_i)
  begin
    if (!rst_ni)
    begin
      stb_cnt <= '0;
      ack_cnt <= '0;
    end
    else
    begin
      if (biu_stb_o && biu_stb_ack_i)
        stb_cnt <= stb_cnt + 1'b1;
      if (mem_ack_o)
        ack_cnt <= ack_cnt + 1'b1;
    end
  end

  ////////////////////
  // Strobe hold
  ////////////////////

  // An unacknowledged strobe repeats with the same fields
  a_stb_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    biu_stb_o && !biu_stb_ack_i |=> biu_stb_o && $stable(biu_adr_o) &&
      $stable(biu_size_o) && $stable(biu_prot_o) && $stable(biu_we_o) && $stable(biu_d_o))
  else
  begin
    fail_cnt++;
    $error("Strobe dropped or changed before its acknowledge");
  end

  ////////////////////
  // Acknowledge
  ////////////////////

  // Acknowledge or error only with a request outstanding
  a_ack_outstanding: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_ack_o || mem_err_o) |-> (ack_cnt < stb_cnt))
  else
  begin
    fail_cnt++;
    $error("Acknowledge without an outstanding request");
  end

  // Back-to-back acknowledges need a second request behind the first
  a_ack_twice: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_ack_o ##1 mem_ack_o |-> (ack_cnt < stb_cnt))
  else
  begin
    fail_cnt++;
    $error("Second acknowledge in a row exceeds the accepted requests");
  end

  // Error is a qualifier of the acknowledge
  a_err_with_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_err_o |-> mem_ack_o)
  else
  begin
    fail_cnt++;
    $error("Error flag without acknowledge");
  end

endmodule

bind nodcache_core mem_subsys_chk #(
  .XLEN (XLEN),
  .PLEN (PLEN)
) u_chk (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .biu_stb_o     (biu_stb_o),
  .biu_stb_ack_i (biu_stb_ack_i),
  .biu_adr_o     (biu_adr_o),
  .biu_size_o    (biu_size_o),
  .biu_prot_o    (biu_prot_o),
  .biu_we_o      (biu_we_o),
  .biu_d_o       (biu_d_o),
  .mem_ack_o     (mem_ack_o),
  .mem_err_o     (mem_err_o)
);

// ==== bench/mem_subsys_tb.sv ====
// Directed tests of the data-memory subsystem with a byte-array reference model
module mem_subsys_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import biu_pkg::*;

  localparam int MEM_BYTES      = DEF_MEM_BYTES;
  localparam int TIMEOUT_CYCLES = 200;
  localparam int RANDOM_REQS    = 48;

  logic        clk;
  logic        rst_n;
  logic        mem_req_i;
  logic [31:0] mem_adr_i;
  biu_size_t   mem_size_i;
  biu_type_t   mem_type_i;
  logic        mem_lock_i;
  biu_prot_t   mem_prot_i;
  logic        mem_we_i;
  logic [31:0] mem_d_i;
  logic [31:0] mem_q_o;
  logic        mem_ack_o;
  logic        mem_err_o;

  // Reference bytes and the responses still expected, in request order
  logic [7:0]  ref_mem [MEM_BYTES];
  logic [31:0] exp_q [$];
  logic        exp_err [$];
  logic        exp_rd [$];
  int unsigned exp_cyc [$];
  int unsigned cycle = 0;
  logic [31:0] lfsr_state = 32'h91f7_b581;

  tb_clock_gen u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  mem_subsys_top #(
    .XLEN        (DEF_XLEN),
    .PLEN        (DEF_PLEN),
    .MEM_BYTES   (MEM_BYTES),
    .QUEUE_DEPTH (DEF_QUEUE_DEPTH)
  ) UUT (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .mem_req_i  (mem_req_i),
    .mem_adr_i  (mem_adr_i),
    .mem_size_i (mem_size_i),
    .mem_type_i (mem_type_i),
    .mem_lock_i (mem_lock_i),
    .mem_prot_i (mem_prot_i),
    .mem_we_i   (mem_we_i),
    .mem_d_i    (mem_d_i),
    .mem_q_o    (mem_q_o),
    .mem_ack_o  (mem_ack_o),
    .mem_err_o  (mem_err_o)
  );

  always @(posedge clk)
    cycle <= cycle + 1;

  ////////////////////
  // Helpers
  ////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hA300_0000) : (lfsr_state >> 1);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // Fill pattern over the whole byte address
  function automatic logic [31:0] fill_word(input logic [31:0] adr);
    return {adr[15:0] ^ 16'hc3a5, ~adr[15:0]} ^ {adr[31:16], adr[31:16]};
  endfunction

  // Alignment, range and protection rules on the byte array
  task automatic model_access(input logic [31:0] adr, input biu_size_t size,
                              input logic priv, input logic we, input logic [31:0] d,
                              output logic [31:0] q, output logic err);
    int          nbytes;
    logic [31:0] base;
    nbytes = (size == BYTE) ? 1 : (size == HWORD) ? 2 : 4;
    err    = (adr % nbytes != 0) || (adr >= MEM_BYTES) ||
             (!priv && adr >= MEM_BYTES - MEM_BYTES / 4);
    q      = '0;
    if (!err)
    begin
      base = adr & ~32'h3;
      for (int i = 0; i < 4; i++)
        q[8*i +: 8] = ref_mem[base + i];
      // Lane k carries the byte for offset k
      if (we)
        for (int i = 0; i < nbytes; i++)
          ref_mem[adr + i] = d[8*((adr % 4) + i) +: 8];
    end
  endtask

  // Present one request and return once the hold has cleared
  task automatic send_req(input logic [31:0] adr, input biu_size_t size,
                          input logic priv, input logic we, input logic [31:0] d);
    logic [31:0] q;
    logic        err;
    int          waited;
    model_access(adr, size, priv, we, d, q, err);
    exp_q.push_back(q);
    exp_err.push_back(err);
    exp_rd.push_back(!we);
    exp_cyc.push_back(cycle);
    mem_req_i  = 1'b1;
    mem_adr_i  = adr;
    mem_size_i = size;
    mem_prot_i = priv ? (PROT_DATA | PROT_PRIVILEGED) : PROT_DATA;
    mem_we_i   = we;
    mem_d_i    = d;
    waited     = 0;
    @(negedge clk);
    while (!UUT.biu_stb_ack)
    begin
      waited++;
      if (waited > TIMEOUT_CYCLES)
        abort_run("Timeout waiting for the strobe acknowledge");
      // Core holds the request from here on
      @(posedge clk);
      #1 mem_req_i = 1'b0;
      @(negedge clk);
    end
    @(posedge clk);
    #1 mem_req_i = 1'b0;
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    while (exp_err.size() != 0)
    begin
      @(posedge clk);
      #1 waited++;
      if (waited > TIMEOUT_CYCLES)
        abort_run("Timeout waiting for outstanding acknowledges");
    end
  endtask

  ////////////////////
  // Response monitor
  ////////////////////

  always @(negedge clk)
  begin : monitor
    logic [31:0] e_q;
    logic        e_err;
    logic        e_rd;
    int unsigned e_cyc;
    if (rst_n && mem_ack_o)
    begin
      if (exp_err.size() == 0)
        abort_run("Acknowledge arrived with no request outstanding");
      e_q   = exp_q.pop_front();
      e_err = exp_err.pop_front();
      e_rd  = exp_rd.pop_front();
      e_cyc = exp_cyc.pop_front();
      assert (mem_err_o == e_err)
      else abort_run($sformatf("[FAIL] %0t ns: error flag %0b, expected %0b",
                               $time, mem_err_o, e_err));
      // Read data, zero on a failing read
      assert (!e_rd || mem_q_o == e_q)
      else abort_run($sformatf("[FAIL] %0t ns: read data %h, expected %h",
                               $time, mem_q_o, e_q));
      assert (cycle - e_cyc >= 4)
      else abort_run($sformatf("[FAIL] %0t ns: acknowledge after %0d cycles, minimum 4",
                               $time, cycle - e_cyc));
    end
  end

  ////////////////////
  // Tests
  ////////////////////

  task automatic wait_reset_release();
    int waited;
    waited = 0;
    while (rst_n !== 1'b1)
    begin
      @(posedge clk);
      waited++;
      if (waited > TIMEOUT_CYCLES)
        abort_run("Timeout waiting for reset release");
    end
    @(negedge clk);
    assert (!mem_ack_o && !mem_err_o && !UUT.biu_stb && !UUT.biu_stb_ack &&
            !UUT.mreq && !UUT.mrsp_valid)
    else abort_run($sformatf("[FAIL] %0t ns: outputs not low after reset", $time));
    @(posedge clk);
    #1;
  endtask

  // Defined contents everywhere before any read
  task automatic fill_memory();
    for (int a = 0; a < MEM_BYTES; a += 4)
      send_req(a, WORD, 1'b1, 1'b1, fill_word(a));
    wait_idle();
  endtask

  task automatic test_word_write_read();
    send_req(32'h040, WORD, 1'b0, 1'b1, 32'hdead_beef);
    send_req(32'h040, WORD, 1'b0, 1'b0, '0);
    wait_idle();
  endtask

  task automatic test_byte_half_lanes();
    for (int off = 0; off < 4; off++)
    begin
      send_req(32'h080 + off, BYTE, 1'b0, 1'b1, 32'(8'h11 * (off + 1)) << (8 * off));
      send_req(32'h080, WORD, 1'b0, 1'b0, '0);
      send_req(32'h080 + off, BYTE, 1'b0, 1'b0, '0);
    end
    for (int off = 0; off < 4; off += 2)
    begin
      send_req(32'h084 + off, HWORD, 1'b0, 1'b1, 32'(16'ha5b6 + off) << (8 * off));
      send_req(32'h084, WORD, 1'b0, 1'b0, '0);
    end
    wait_idle();
  endtask

  task automatic test_access_errors();
    send_req(32'h101, HWORD, 1'b0, 1'b1, 32'h1234_5678);
    send_req(32'h102, WORD, 1'b0, 1'b1, 32'h1234_5678);
    send_req(32'h103, WORD, 1'b0, 1'b0, '0);
    send_req(32'h400, WORD, 1'b1, 1'b1, 32'hcafe_f00d);
    send_req(32'h8000_0000, BYTE, 1'b1, 1'b0, '0);
    // Neighbours of the rejected accesses stay as filled
    send_req(32'h100, WORD, 1'b0, 1'b0, '0);
    send_req(32'h3fc, WORD, 1'b1, 1'b0, '0);
    // Word 0 is where the out-of-range write would wrap to
    send_req(32'h000, WORD, 1'b0, 1'b0, '0);
    wait_idle();
  endtask

  task automatic test_protection();
    send_req(32'h300, WORD, 1'b0, 1'b1, 32'h0bad_0bad);
    send_req(32'h380, BYTE, 1'b0, 1'b0, '0);
    send_req(32'h300, WORD, 1'b1, 1'b0, '0);
    send_req(32'h300, WORD, 1'b1, 1'b1, 32'h600d_600d);
    send_req(32'h300, WORD, 1'b1, 1'b0, '0);
    send_req(32'h2fc, WORD, 1'b0, 1'b0, '0);
    wait_idle();
  endtask

  task automatic test_back_to_back();
    logic [31:0] adr;
    logic [1:0]  sel;
    biu_size_t   size;
    logic        priv;
    logic        we;
    logic [31:0] d;
    for (int n = 0; n < RANDOM_REQS; n++)
    begin
      adr  = rand_bits(10);
      sel  = 2'(rand_bits(2));
      size = (sel == 2'd0) ? BYTE : (sel == 2'd1) ? HWORD : WORD;
      if (size == HWORD)
        adr[0] = 1'b0;
      if (size == WORD)
        adr[1:0] = 2'b00;
      priv = 1'(rand_bits(1));
      we   = 1'(rand_bits(1));
      d    = rand_bits(32);
      send_req(adr, size, priv, we, d);
    end
    wait_idle();
  endtask

  initial
  begin
    mem_req_i  = 1'b0;
    mem_adr_i  = '0;
    mem_size_i = WORD;
    mem_type_i = SINGLE;
    mem_lock_i = 1'b0;
    mem_prot_i = PROT_DATA;
    mem_we_i   = 1'b0;
    mem_d_i    = '0;
    wait_reset_release();
    fill_memory();
    test_word_write_read();
    test_byte_half_lanes();
    test_access_errors();
    test_protection();
    test_back_to_back();
    if (UUT.u_core.u_chk.fail_cnt == 0)
    begin
      $display("Test completed successfully");
      $finish;
    end
    else
    begin
      $display("Test failed");
      $fatal(1, "Protocol checks reported %0d failures", UUT.u_core.u_chk.fail_cnt);
    end
  end

endmodule

// ==== bench/tb_clock_gen.sv ====
// Testbench clock and reset generator
module tb_clock_gen #(
  parameter int HALF_PERIOD  = 5,
  parameter int RESET_CYCLES = 10
)
(
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 100ps;

  // 10 ns period
  initial
  begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // Reset low for the first cycles, released just after an edge
  initial
  begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

// ==== files.f ====
logic/biu_pkg.sv
logic/biu_queue.sv
logic/nodcache_core.sv
logic/biu_ctrl.sv
logic/scratch_mem.sv
logic/mem_subsys_top.sv
bench/tb_clock_gen.sv
bench/mem_subsys_chk.sv
bench/mem_subsys_tb.sv

// ==== logic/biu_ctrl.sv ====
// Bus interface unit: strobe accept, request queue, credit-based memory issue, response queue
module biu_ctrl #(
  parameter int XLEN        = biu_pkg::DEF_XLEN,
  parameter int PLEN        = biu_pkg::DEF_PLEN,
  parameter int QUEUE_DEPTH = biu_pkg::DEF_QUEUE_DEPTH
)
(
  input  logic                clk_i,
  input  logic                rst_ni,

  // Core side
  input  logic                stb_i,
  output logic                stb_ack_o,
  input  logic [PLEN-1:0]     adr_i,
  input  biu_pkg::biu_size_t  size_i,
  input  biu_pkg::biu_type_t  type_i,
  input  logic                lock_i,
  input  biu_pkg::biu_prot_t  prot_i,
  input  logic                we_i,
  input  logic [XLEN-1:0]     d_i,
  output logic [XLEN-1:0]     q_o,
  output logic                ack_o,
  output logic                err_o,

  // Memory side
  output logic                mreq_o,
  output logic [PLEN-1:0]     madr_o,
  output biu_pkg::biu_size_t  msize_o,
  output logic                mpriv_o,
  output logic                mwe_o,
  output logic [XLEN-1:0]     md_o,
  input  logic                mrsp_valid_i,
  input  logic [XLEN-1:0]     mrsp_q_i,
  input  logic                mrsp_err_i
);
  import biu_pkg::*;

  localparam int CW = $clog2(QUEUE_DEPTH+1);

  biu_req_t      req_in;
  biu_req_t      req_head;
  logic          req_full;
  logic          req_empty;
  biu_rsp_t      rsp_in;
  biu_rsp_t      rsp_head;
  logic          rsp_empty;
  logic [CW-1:0] rsp_count;
  logic [CW-1:0] in_flight;
  logic [CW-1:0] slots_used;
  logic          issue;

  ////////////////////
  // Request side
  ////////////////////

  // Acknowledge a strobe whenever there is room
  assign stb_ack_o = stb_i & ~req_full;

  // Type and lock are accepted but not carried, single transfers only
  always_comb
  begin
    req_in       = '0;
    req_in.adr   = adr_i;
    req_in.d     = d_i;
    req_in.size  = size_i;
    req_in.prot  = prot_i & PROT_PRIVILEGED;
    req_in.we    = we_i;
    req_in.spare = 1'b0;
  end

  biu_queue #(
    .elem_t (biu_req_t),
    .DEPTH  (QUEUE_DEPTH)
  ) u_req_queue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (stb_ack_o),
    .push_data_i (req_in),
    .full_o      (req_full),
    .pop_i       (issue),
    .pop_data_o  (req_head),
    .empty_o     (req_empty),
    .count_o     ()
  );

  ////////////////////
  // Memory issue
  ////////////////////

  // Credits: every access in flight reserves a response slot
  assign slots_used = in_flight + rsp_count;
  assign issue      = ~req_empty & (slots_used < CW'(QUEUE_DEPTH));

  always_ff @(posedge clk_i)
  begin
    if (!rst_ni)
      in_flight <= '0;
    else if (issue && !mrsp_valid_i)
      in_flight <= in_flight + 1'b1;
    else if (mrsp_valid_i && !issue)
      in_flight <= in_flight - 1'b1;
  end

  assign mreq_o  = issue;
  assign madr_o  = req_head.adr;
  assign msize_o = req_head.size;
  assign mpriv_o = req_head.prot[1];
  assign mwe_o   = req_head.we;
  assign md_o    = req_head.d;

  ////////////////////
  // Response side
  ////////////////////

  assign rsp_in.q   = mrsp_q_i;
  assign rsp_in.err = mrsp_err_i;

  biu_queue #(
    .elem_t (biu_rsp_t),
    .DEPTH  (QUEUE_DEPTH)
  ) u_rsp_queue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (mrsp_valid_i),
    .push_data_i (rsp_in),
    .full_o      (),
    .pop_i       (ack_o),
    .pop_data_o  (rsp_head),
    .empty_o     (rsp_empty),
    .count_o     (rsp_count)
  );

  // One acknowledge pulse per cycle while responses wait
  assign ack_o = ~rsp_empty;
  assign q_o   = rsp_head.q;
  assign err_o = ~rsp_empty & rsp_head.err;

endmodule

// ==== logic/biu_pkg.sv ====
// Bus interface package: size, burst type and protection types, request and response records, default sizes
package biu_pkg;

  ////////////////////
  // Default sizes
  ////////////////////

  // Data and physical address widths
  localparam int DEF_XLEN        = 32;
  localparam int DEF_PLEN        = 32;
  // Scratch memory size in bytes, power of two
  localparam int DEF_MEM_BYTES   = 1024;
  // Entries in each BIU queue
  localparam int DEF_QUEUE_DEPTH = 4;

  ////////////////////
  // Transfer attributes
  ////////////////////

  // Transfer size
  typedef enum logic [1:0] {
    BYTE  = 2'b00,
    HWORD = 2'b01,
    WORD  = 2'b10
  } biu_size_t;

  // Burst type, only SINGLE is executed
  typedef enum logic [2:0] {
    SINGLE = 3'b000,
    INCR   = 3'b001,
    INCR4  = 3'b010,
    INCR8  = 3'b011
  } biu_type_t;

  // Protection bits
  typedef logic [2:0] biu_prot_t;
  localparam biu_prot_t PROT_DATA       = 3'b001;
  localparam biu_prot_t PROT_PRIVILEGED = 3'b010;

  ////////////////////
  // Queue records
  ////////////////////

  // Request as held in the BIU request queue (71 bits)
  typedef struct packed {
    logic [DEF_PLEN-1:0] adr;
    logic [DEF_XLEN-1:0] d;
    biu_size_t           size;
    biu_prot_t           prot;  // only the privileged bit is kept
    logic                we;
    logic                spare; // reserved, always 0
  } biu_req_t;

  // Response as held in the BIU response queue (33 bits)
  typedef struct packed {
    logic [DEF_XLEN-1:0] q;
    logic                err;
  } biu_rsp_t;

endpackage

// ==== logic/biu_queue.sv ====
// In-order circular FIFO with a type-parameter element, used for BIU requests and responses
module biu_queue #(
  parameter type elem_t = logic [7:0],
  parameter int  DEPTH  = 4
)
(
  input  logic                       clk_i,
  input  logic                       rst_ni,

  // Write side
  input  logic                       push_i,
  input  elem_t                      push_data_i,
  output logic                       full_o,

  // Read side
  input  logic                       pop_i,
  output elem_t                      pop_data_o,
  output logic                       empty_o,
  output logic [$clog2(DEPTH+1)-1:0] count_o
);

  localparam int AW = $clog2(DEPTH);
  localparam int CW = $clog2(DEPTH+1);

  elem_t         mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          do_push;
  logic          do_pop;

  // Pushes into a full queue and pops from an empty one are ignored
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // Storage, no reset
  always_ff @(posedge clk_i)
  begin
    if (do_push)
      mem[wr_ptr] <= push_data_i;
  end

  // Pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge clk_i)
  begin
    if (!rst_ni)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

  // Head is visible the cycle after its push
  assign pop_data_o = mem[rd_ptr];
  assign empty_o    = (count == '0);
  assign full_o     = (count == CW'(DEPTH));
  assign count_o    = count;

endmodule

// ==== logic/mem_subsys_top.sv ====
// Data-memory subsystem top level: no-data-cache core, BIU and scratch memory
module mem_subsys_top #(
  parameter int XLEN        = biu_pkg::DEF_XLEN,
  parameter int PLEN        = biu_pkg::DEF_PLEN,
  parameter int MEM_BYTES   = biu_pkg::DEF_MEM_BYTES,
  parameter int QUEUE_DEPTH = biu_pkg::DEF_QUEUE_DEPTH
)
(
  input  logic                clk_i,
  input  logic                rst_ni,

  // CPU data port
  input  logic                mem_req_i,
  input  logic [PLEN-1:0]     mem_adr_i,
  input  biu_pkg::biu_size_t  mem_size_i,
  input  biu_pkg::biu_type_t  mem_type_i,
  input  logic                mem_lock_i,
  input  biu_pkg::biu_prot_t  mem_prot_i,
  input  logic                mem_we_i,
  input  logic [XLEN-1:0]     mem_d_i,
  output logic [XLEN-1:0]     mem_q_o,
  output logic                mem_ack_o,
  output logic                mem_err_o
);
  import biu_pkg::*;

  ////////////////////
  // Core to BIU
  ////////////////////

  logic            biu_stb;
  logic            biu_stb_ack;
  logic [PLEN-1:0] biu_adr;
  biu_size_t       biu_size;
  biu_type_t       biu_type;
  logic            biu_lock;
  biu_prot_t       biu_prot;
  logic            biu_we;
  logic [XLEN-1:0] biu_d;
  logic [XLEN-1:0] biu_q;
  logic            biu_ack;
  logic            biu_err;

  ////////////////////
  // BIU to memory
  ////////////////////

  logic            mreq;
  logic [PLEN-1:0] madr;
  biu_size_t       msize;
  logic            mpriv;
  logic            mwe;
  logic [XLEN-1:0] md;
  logic            mrsp_valid;
  logic [XLEN-1:0] mrsp_q;
  logic            mrsp_err;

  nodcache_core #(
    .XLEN (XLEN),
    .PLEN (PLEN)
  ) u_core (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .mem_req_i     (mem_req_i),
    .mem_adr_i     (mem_adr_i),
    .mem_size_i    (mem_size_i),
    .mem_type_i    (mem_type_i),
    .mem_lock_i    (mem_lock_i),
    .mem_prot_i    (mem_prot_i),
    .mem_we_i      (mem_we_i),
    .mem_d_i       (mem_d_i),
    .mem_q_o       (mem_q_o),
    .mem_ack_o     (mem_ack_o),
    .mem_err_o     (mem_err_o),
    .biu_stb_o     (biu_stb),
    .biu_stb_ack_i (biu_stb_ack),
    .biu_adr_o     (biu_adr),
    .biu_size_o    (biu_size),
    .biu_type_o    (biu_type),
    .biu_lock_o    (biu_lock),
    .biu_prot_o    (biu_prot),
    .biu_we_o      (biu_we),
    .biu_d_o       (biu_d),
    .biu_q_i       (biu_q),
    .biu_ack_i     (biu_ack),
    .biu_err_i     (biu_err)
  );

  biu_ctrl #(
    .XLEN        (XLEN),
    .PLEN        (PLEN),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_biu (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .stb_i        (biu_stb),
    .stb_ack_o    (biu_stb_ack),
    .adr_i        (biu_adr),
    .size_i       (biu_size),
    .type_i       (biu_type),
    .lock_i       (biu_lock),
    .prot_i       (biu_prot),
    .we_i         (biu_we),
    .d_i          (biu_d),
    .q_o          (biu_q),
    .ack_o        (biu_ack),
    .err_o        (biu_err),
    .mreq_o       (mreq),
    .madr_o       (madr),
    .msize_o      (msize),
    .mpriv_o      (mpriv),
    .mwe_o        (mwe),
    .md_o         (md),
    .mrsp_valid_i (mrsp_valid),
    .mrsp_q_i     (mrsp_q),
    .mrsp_err_i   (mrsp_err)
  );

  // Memory ports use the package default widths
  scratch_mem #(
    .MEM_BYTES (MEM_BYTES)
  ) u_mem (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .mreq_i       (mreq),
    .madr_i       (madr),
    .msize_i      (msize),
    .mpriv_i      (mpriv),
    .mwe_i        (mwe),
    .md_i         (md),
    .mrsp_valid_o (mrsp_valid),
    .mrsp_q_o     (mrsp_q),
    .mrsp_err_o   (mrsp_err)
  );

endmodule

// ==== logic/nodcache_core.sv ====
// Data-side request hold stage between the CPU port and the BIU strobe handshake
module nodcache_core #(
  parameter int XLEN = biu_pkg::DEF_XLEN,
  parameter int PLEN = biu_pkg::DEF_PLEN
)
(
  input  logic                clk_i,
  input  logic                rst_ni,

  // CPU side
  input  logic                mem_req_i,
  input  logic [PLEN-1:0]     mem_adr_i,
  input  biu_pkg::biu_size_t  mem_size_i,
  input  biu_pkg::biu_type_t  mem_type_i,
  input  logic                mem_lock_i,
  input  biu_pkg::biu_prot_t  mem_prot_i,
  input  logic                mem_we_i,
  input  logic [XLEN-1:0]     mem_d_i,
  output logic [XLEN-1:0]     mem_q_o,
  output logic                mem_ack_o,
  output logic                mem_err_o,

  // BIU side
  output logic                biu_stb_o,
  input  logic                biu_stb_ack_i,
  output logic [PLEN-1:0]     biu_adr_o,
  output biu_pkg::biu_size_t  biu_size_o,
  output biu_pkg::biu_type_t  biu_type_o,
  output logic                biu_lock_o,
  output biu_pkg::biu_prot_t  biu_prot_o,
  output logic                biu_we_o,
  output logic [XLEN-1:0]     biu_d_o,
  input  logic [XLEN-1:0]     biu_q_i,
  input  logic                biu_ack_i,
  input  logic                biu_err_i
);
  import biu_pkg::*;

  ////////////////////
  // Hold registers
  ////////////////////

  logic            hold_req;
  logic [PLEN-1:0] hold_adr;
  logic [XLEN-1:0] hold_d;
  biu_size_t       hold_size;
  biu_type_t       hold_type;
  biu_prot_t       hold_prot;
  logic            hold_lock;
  logic            hold_we;

  // Capture a new request, the held copy stays until the strobe is taken
  always_ff @(posedge clk_i)
  begin
    if (mem_req_i && !hold_req)
    begin
      hold_adr  <= mem_adr_i;
      hold_size <= mem_size_i;
      hold_type <= mem_type_i;
      hold_lock <= mem_lock_i;
      hold_prot <= mem_prot_i;
      hold_we   <= mem_we_i;
      hold_d    <= mem_d_i;
    end
  end

  // Hold flag clears the cycle after the acknowledge
  always_ff @(posedge clk_i)
  begin
    if (!rst_ni)
      hold_req <= 1'b0;
    else
      hold_req <= (mem_req_i | hold_req) & ~biu_stb_ack_i;
  end

  ////////////////////
  // Strobe to BIU
  ////////////////////

  // Live request in its first cycle, held copy after that
  assign biu_stb_o  = mem_req_i | hold_req;
  assign biu_adr_o  = hold_req ? hold_adr  : mem_adr_i;
  assign biu_size_o = hold_req ? hold_size : mem_size_i;
  assign biu_type_o = hold_req ? hold_type : mem_type_i;
  assign biu_lock_o = hold_req ? hold_lock : mem_lock_i;
  assign biu_prot_o = hold_req ? hold_prot : mem_prot_i;
  assign biu_we_o   = hold_req ? hold_we   : mem_we_i;
  assign biu_d_o    = hold_req ? hold_d    : mem_d_i;

  // Responses go straight back to the CPU
  assign mem_q_o   = biu_q_i;
  assign mem_ack_o = biu_ack_i;
  assign mem_err_o = biu_err_i;

endmodule

// ==== logic/scratch_mem.sv ====
// Byte-lane scratch memory with alignment, range and protection checks and a two-cycle response
module scratch_mem #(
  parameter int MEM_BYTES = biu_pkg::DEF_MEM_BYTES
)
(
  input  logic                          clk_i,
  input  logic                          rst_ni,

  // Access from the BIU
  input  logic                          mreq_i,
  input  logic [biu_pkg::DEF_PLEN-1:0]  madr_i,
  input  biu_pkg::biu_size_t            msize_i,
  input  logic                          mpriv_i,
  input  logic                          mwe_i,
  input  logic [biu_pkg::DEF_XLEN-1:0]  md_i,

  // Response, two cycles after the access
  output logic                          mrsp_valid_o,
  output logic [biu_pkg::DEF_XLEN-1:0]  mrsp_q_o,
  output logic                          mrsp_err_o
);
  import biu_pkg::*;

  localparam int WORDS = MEM_BYTES / 4;
  localparam int AW    = $clog2(WORDS);

  logic [DEF_XLEN-1:0] mem [WORDS];
  logic [AW-1:0]       widx;
  logic [3:0]          be;
  logic                misaligned;
  logic                out_of_range;
  logic                prot_fail;
  logic                acc_err;
  logic                s1_valid;
  logic                s1_err;
  logic [DEF_XLEN-1:0] s1_q;

  ////////////////////
  // Access checks
  ////////////////////

  assign widx = madr_i[AW+1:2];

  // Byte enables from size and low address bits
  always_comb
  begin
    case (msize_i)
      BYTE:    be = 4'b0001 << madr_i[1:0];
      HWORD:   be = 4'b0011 << madr_i[1:0];
      WORD:    be = 4'b1111;
      default: be = 4'b0000;
    endcase
  end

  // Unknown size codes count as misaligned
  assign misaligned   = (msize_i == HWORD && madr_i[0]) ||
                        (msize_i == WORD && madr_i[1:0] != 2'b00) ||
                        (be == 4'b0000);
  assign out_of_range = (madr_i >= DEF_PLEN'(MEM_BYTES));
  // Upper quarter is privileged only
  assign prot_fail    = !mpriv_i && (madr_i >= DEF_PLEN'(MEM_BYTES - MEM_BYTES / 4));
  assign acc_err      = misaligned | out_of_range | prot_fail;

  ////////////////////
  // Array and pipe
  ////////////////////

  // Failing accesses write nothing
  always_ff @(posedge clk_i)
  begin
    if (mreq_i && mwe_i && !acc_err)
    begin
      for (int i = 0; i < 4; i++)
      begin
        if (be[i])
          mem[widx][8*i +: 8] <= md_i[8*i +: 8];
      end
    end
  end

  // Stage 1 reads the full word, stage 2 drives the response
  always_ff @(posedge clk_i)
  begin
    s1_q <= mem[widx];
    mrsp_q_o <= s1_err ? '0 : s1_q;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_ni)
    begin
      s1_valid     <= 1'b0;
      s1_err       <= 1'b0;
      mrsp_valid_o <= 1'b0;
      mrsp_err_o   <= 1'b0;
    end
    else
    begin
      s1_valid     <= mreq_i;
      s1_err       <= mreq_i & acc_err;
      mrsp_valid_o <= s1_valid;
      mrsp_err_o   <= s1_valid & s1_err;
    end
  end

endmodule
